// File: boot_loader_top.sv
`timescale 1ns/100ps

module boot_loader_top import boot_pkg::*; #(
	parameter int CLKS_PER_BIT = 16,
	parameter int ADDR_W       = 8,
	parameter int QUEUE_DEPTH  = 4
) (
	input  logic              clk_i,
	input  logic              enable_rst_ni,
	input  logic              uart_rx_i,
	input  logic              fetch_req_i,
	input  logic [ADDR_W-1:0] fetch_addr_i,
	output logic [DATA_W-1:0] fetch_data_o,
	output logic              fetch_valid_o,
	output logic              sys_rst_no,
	output logic              overrun_o
);

	logic              rx_valid;
	logic [7:0]        rx_byte;
	logic              push;
	item_op_e          push_op;
	logic [ADDR_W-1:0] push_addr;
	logic [DATA_W-1:0] push_data;
	logic              credit_return;
	logic              mem_we;
	logic [ADDR_W-1:0] mem_waddr;
	logic [DATA_W-1:0] mem_wdata;
	logic              load_done;

	// ==========================================================
	// Load path, UART to instruction memory
	// ==========================================================

	uart_byte_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart_rx (
		.clk_i        (clk_i),
		.enable_rst_ni(enable_rst_ni),
		.rx_i         (uart_rx_i),
		.rx_valid_o   (rx_valid),
		.rx_byte_o    (rx_byte)
	);

	word_packer #(
		.ADDR_W     (ADDR_W),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_packer (
		.clk_i          (clk_i),
		.enable_rst_ni  (enable_rst_ni),
		.rx_valid_i     (rx_valid),
		.rx_byte_i      (rx_byte),
		.credit_return_i(credit_return),
		.push_o         (push),
		.push_op_o      (push_op),
		.push_addr_o    (push_addr),
		.push_data_o    (push_data),
		.overrun_o      (overrun_o)
	);

	iccm_write_queue #(
		.ADDR_W     (ADDR_W),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_wr_queue (
		.clk_i          (clk_i),
		.enable_rst_ni  (enable_rst_ni),
		.push_i         (push),
		.push_op_i      (push_op),
		.push_addr_i    (push_addr),
		.push_data_i    (push_data),
		.fetch_req_i    (fetch_req_i),
		.mem_we_o       (mem_we),
		.mem_waddr_o    (mem_waddr),
		.mem_wdata_o    (mem_wdata),
		.credit_return_o(credit_return),
		.load_done_o    (load_done)
	);

	iccm_sram #(
		.ADDR_W(ADDR_W)
	) u_iccm (
		.clk_i        (clk_i),
		.enable_rst_ni(enable_rst_ni),
		.we_i         (mem_we),
		.waddr_i      (mem_waddr),
		.wdata_i      (mem_wdata),
		.req_i        (fetch_req_i),
		.raddr_i      (fetch_addr_i),
		.rdata_o      (fetch_data_o),
		.rvalid_o     (fetch_valid_o)
	);

	boot_rstmgr u_rstmgr (
		.clk_i        (clk_i),
		.enable_rst_ni(enable_rst_ni),
		.load_done_i  (load_done),
		.sys_rst_no   (sys_rst_no)
	);

endmodule

// File: boot_pkg.sv
package boot_pkg;

	// ==========================================================
	// Word format
	// ==========================================================

	// Instruction word width
	localparam int DATA_W = 32;

	localparam int BYTE_W = 8;
	localparam int BYTES_PER_WORD = DATA_W / BYTE_W;

	// End-of-program marker sent by the host after the last word
	localparam logic [DATA_W-1:0] DONE_WORD = 32'h0000_0FFF;

	// ==========================================================
	// Write queue items
	// ==========================================================

	typedef enum logic {
		ITEM_WRITE = 1'b0,
		ITEM_DONE  = 1'b1
	} item_op_e;

endpackage

// File: boot_rstmgr.sv
`timescale 1ns/100ps

module boot_rstmgr (
	input  logic clk_i,
	input  logic enable_rst_ni,
	input  logic load_done_i,
	output logic sys_rst_no
);

	typedef enum logic {
		LOADING,
		RUN
	} rst_state_e;

	rst_state_e state_q;
	rst_state_e state_d;
	logic       sys_rst_q;

	// Leave LOADING once the DONE item is popped
	always_comb begin
		state_d = state_q;
		case (state_q)
			LOADING: begin
				if (load_done_i) begin
					state_d = RUN;
				end
			end
			RUN:     state_d = RUN;
			default: state_d = LOADING;
		endcase
	end

	// System held in reset while loading
	always_ff @(posedge clk_i or negedge enable_rst_ni) begin
		if (!enable_rst_ni) begin
			state_q   <= LOADING;
			sys_rst_q <= 1'b0;
		end else begin
			state_q   <= state_d;
			sys_rst_q <= (state_d == RUN);
		end
	end

	assign sys_rst_no = sys_rst_q;

endmodule

// File: iccm_sram.sv
`timescale 1ns/100ps

module iccm_sram import boot_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  logic              clk_i,
	input  logic              enable_rst_ni,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] waddr_i,
	input  logic [DATA_W-1:0] wdata_i,
	input  logic              req_i,
	input  logic [ADDR_W-1:0] raddr_i,
	output logic [DATA_W-1:0] rdata_o,
	output logic              rvalid_o
);

	localparam int WORDS = 2 ** ADDR_W;

	logic [DATA_W-1:0] mem [WORDS];

	// ==========================================================
	// Single port array
	// ==========================================================

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		if (req_i) begin
			rdata_o <= mem[raddr_i];
		end
	end

	// Data valid one cycle after the request
	always_ff @(posedge clk_i or negedge enable_rst_ni) begin
		if (!enable_rst_ni) begin
			rvalid_o <= 1'b0;
		end else begin
			rvalid_o <= req_i;
		end
	end

	// Write queue must yield the single port to fetch
	a_port_conflict: assert property (@(posedge clk_i) disable iff (!enable_rst_ni)
		!(we_i && req_i))
		else $error("write and fetch in same cycle, waddr %h raddr %h", waddr_i, raddr_i);

endmodule

// File: iccm_write_queue.sv
`timescale 1ns/100ps

module iccm_write_queue import boot_pkg::*; #(
	parameter int ADDR_W      = 8,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic              clk_i,
	input  logic              enable_rst_ni,
	input  logic              push_i,
	input  item_op_e          push_op_i,
	input  logic [ADDR_W-1:0] push_addr_i,
	input  logic [DATA_W-1:0] push_data_i,
	input  logic              fetch_req_i,
	output logic              mem_we_o,
	output logic [ADDR_W-1:0] mem_waddr_o,
	output logic [DATA_W-1:0] mem_wdata_o,
	output logic              credit_return_o,
	output logic              load_done_o
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	item_op_e          op_mem   [QUEUE_DEPTH];
	logic [ADDR_W-1:0] addr_mem [QUEUE_DEPTH];
	logic [DATA_W-1:0] data_mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [CNT_W-1:0] count_q;
	logic             empty;
	logic             full;
	logic             pop;

	assign empty = (count_q == '0);
	assign full  = (count_q == CNT_W'(QUEUE_DEPTH));

	// Fetch port has priority over loading
	assign pop = !empty && !fetch_req_i;

	// ==========================================================
	// Pointers and fill level
	// ==========================================================

	always_ff @(posedge clk_i or negedge enable_rst_ni) begin
		if (!enable_rst_ni) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (push_i) begin
				if (tail_q == PTR_W'(QUEUE_DEPTH - 1)) begin
					tail_q <= '0;
				end else begin
					tail_q <= tail_q + 1'b1;
				end
			end
			if (pop) begin
				if (head_q == PTR_W'(QUEUE_DEPTH - 1)) begin
					head_q <= '0;
				end else begin
					head_q <= head_q + 1'b1;
				end
			end
			case ({push_i, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			op_mem[tail_q]   <= push_op_i;
			addr_mem[tail_q] <= push_addr_i;
			data_mem[tail_q] <= push_data_i;
		end
	end

	// Head item decode, DONE writes nothing
	assign mem_we_o        = pop && (op_mem[head_q] == ITEM_WRITE);
	assign load_done_o     = pop && (op_mem[head_q] == ITEM_DONE);
	assign mem_waddr_o     = addr_mem[head_q];
	assign mem_wdata_o     = data_mem[head_q];
	assign credit_return_o = pop;

	// Packer credits must keep the FIFO from overflowing
	a_no_push_full: assert property (@(posedge clk_i) disable iff (!enable_rst_ni)
		!(push_i && full))
		else $error("push into full write queue");

endmodule

// File: project.f
boot_pkg.sv
uart_byte_rx.sv
word_packer.sv
iccm_write_queue.sv
iccm_sram.sv
boot_rstmgr.sv
boot_loader_top.sv
tb_boot_loader.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the boot loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_boot_loader \
	-f project.f -o sim_boot_loader \
	&& ./obj_dir/sim_boot_loader | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_boot_loader.sv
`timescale 1ns/100ps

module tb_boot_loader import boot_pkg::*;;

	localparam int CLKS_PER_BIT = 8;
	localparam int ADDR_W       = 8;
	localparam int QUEUE_DEPTH  = 4;
	localparam int CLK_NS       = 20;
	// 6 words, DONE, 1 word after DONE, 5 back-pressure words, glitch and 1 word
	localparam int NUM_FRAMES   = 24 + 4 + 4 + 20 + 5;
	localparam int WATCHDOG_NS  = NUM_FRAMES * 10 * CLKS_PER_BIT * CLK_NS * 2;

	logic              clk_i;
	logic              enable_rst_ni;
	logic              uart_rx_i;
	logic              fetch_req_i;
	logic [ADDR_W-1:0] fetch_addr_i;
	logic [DATA_W-1:0] fetch_data_o;
	logic              fetch_valid_o;
	logic              sys_rst_no;
	logic              overrun_o;

	logic [15:0]       lfsr_q;
	logic [DATA_W-1:0] prog [6];
	logic [DATA_W-1:0] bp_words [5];
	logic [DATA_W-1:0] slot6_init;
	int                errors;

	boot_loader_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.ADDR_W      (ADDR_W),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) DUT (
		.clk_i        (clk_i),
		.enable_rst_ni(enable_rst_ni),
		.uart_rx_i    (uart_rx_i),
		.fetch_req_i  (fetch_req_i),
		.fetch_addr_i (fetch_addr_i),
		.fetch_data_o (fetch_data_o),
		.fetch_valid_o(fetch_valid_o),
		.sys_rst_no   (sys_rst_no),
		.overrun_o    (overrun_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_NS / 2) clk_i = ~clk_i;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

	// ==========================================================
	// Stimulus helpers
	// ==========================================================

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic next_word(output logic [DATA_W-1:0] w);
		w = '0;
		for (int i = 0; i < DATA_W; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			w = {w[DATA_W-2:0], lfsr_q[0]};
		end
	endtask

	task automatic apply_reset();
		enable_rst_ni <= 1'b0;
		repeat (5) @(posedge clk_i);
		enable_rst_ni <= 1'b1;
		@(posedge clk_i);
	endtask

	// 8N1 frame, LSB first
	task automatic send_byte(input logic [7:0] b);
		uart_rx_i <= 1'b0;
		repeat (CLKS_PER_BIT) @(posedge clk_i);
		for (int i = 0; i < 8; i++) begin
			uart_rx_i <= b[i];
			repeat (CLKS_PER_BIT) @(posedge clk_i);
		end
		uart_rx_i <= 1'b1;
		repeat (CLKS_PER_BIT) @(posedge clk_i);
	endtask

	task automatic send_word(input logic [DATA_W-1:0] w);
		for (int i = 0; i < 4; i++) begin
			send_byte(w[i*8 +: 8]);
		end
	endtask

	task automatic send_glitch();
		uart_rx_i <= 1'b0;
		repeat (2) @(posedge clk_i);
		uart_rx_i <= 1'b1;
		repeat (2 * CLKS_PER_BIT) @(posedge clk_i);
	endtask

	task automatic fetch_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		fetch_req_i  <= 1'b1;
		fetch_addr_i <= addr;
		@(posedge clk_i);
		fetch_req_i <= 1'b0;
		// Registered read, data one cycle after the request
		@(negedge clk_i);
		if (fetch_valid_o !== 1'b1) begin
			$display("[ERROR] fetch_valid_o addr %h: got %h expected %h",
				addr, fetch_valid_o, 1'b1);
			errors++;
		end
		data = fetch_data_o;
		@(posedge clk_i);
		@(negedge clk_i);
		if (fetch_valid_o !== 1'b0) begin
			$display("[ERROR] fetch_valid_o after addr %h: got %h expected %h",
				addr, fetch_valid_o, 1'b0);
			errors++;
		end
		@(posedge clk_i);
	endtask

	task automatic read_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] got;
		fetch_word(addr, got);
		if (got !== exp) begin
			$display("[ERROR] fetch_data_o addr %h: got %h expected %h", addr, got, exp);
			errors++;
		end
	endtask

	task automatic check_flags(input logic exp_rst, input logic exp_ovr);
		@(negedge clk_i);
		if (sys_rst_no !== exp_rst) begin
			$display("[ERROR] sys_rst_no: got %h expected %h", sys_rst_no, exp_rst);
			errors++;
		end
		if (overrun_o !== exp_ovr) begin
			$display("[ERROR] overrun_o: got %h expected %h", overrun_o, exp_ovr);
			errors++;
		end
		@(posedge clk_i);
	endtask

	task automatic wait_rst_release();
		int waited;
		waited = 0;
		@(negedge clk_i);
		while (!sys_rst_no && waited < 64) begin
			@(negedge clk_i);
			waited++;
		end
		if (!sys_rst_no) begin
			$display("sys_rst_no did not rise after the end-of-program word");
			errors++;
		end
		@(posedge clk_i);
	endtask

	// ==========================================================
	// Directed tests
	// ==========================================================

	task automatic test_load_words();
		check_flags(1'b0, 1'b0);
		for (int i = 0; i < 6; i++) begin
			next_word(prog[i]);
			send_word(prog[i]);
		end
		for (int i = 0; i < 6; i++) begin
			read_word(ADDR_W'(i), prog[i]);
		end
	endtask

	task automatic test_done_word();
		check_flags(1'b0, 1'b0);
		fetch_word(ADDR_W'(6), slot6_init);
		send_word(DONE_WORD);
		wait_rst_release();
		check_flags(1'b1, 1'b0);
		read_word(ADDR_W'(6), slot6_init);
	endtask

	task automatic test_after_done();
		logic [DATA_W-1:0] extra;
		next_word(extra);
		send_word(extra);
		for (int i = 0; i < 6; i++) begin
			read_word(ADDR_W'(i), prog[i]);
		end
		// Next free address after the DONE item
		read_word(ADDR_W'(6), slot6_init);
	endtask

	task automatic test_back_pressure();
		apply_reset();
		fetch_req_i <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			next_word(bp_words[i]);
			send_word(bp_words[i]);
		end
		check_flags(1'b0, 1'b0);
		next_word(bp_words[4]);
		send_word(bp_words[4]);
		check_flags(1'b0, 1'b1);
		// Queue drains one item per idle cycle
		fetch_req_i <= 1'b0;
		repeat (QUEUE_DEPTH + 1) @(posedge clk_i);
		for (int i = 0; i < 4; i++) begin
			read_word(ADDR_W'(i), bp_words[i]);
		end
		// Dropped word leaves the first load in place
		read_word(ADDR_W'(4), prog[4]);
	endtask

	task automatic test_start_glitch();
		logic [DATA_W-1:0] w;
		send_glitch();
		next_word(w);
		send_word(w);
		read_word(ADDR_W'(4), w);
		check_flags(1'b0, 1'b1);
	endtask

	initial begin
		errors = 0;
		lfsr_q = 16'd53;
		enable_rst_ni <= 1'b0;
		uart_rx_i     <= 1'b1;
		fetch_req_i   <= 1'b0;
		fetch_addr_i  <= '0;
		@(posedge clk_i);
		apply_reset();

		test_load_words();
		test_done_word();
		test_after_done();
		test_back_pressure();
		test_start_glitch();

		$display("checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: uart_byte_rx.sv
`timescale 1ns/100ps

module uart_byte_rx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       clk_i,
	input  logic       enable_rst_ni,
	input  logic       rx_i,
	output logic       rx_valid_o,
	output logic [7:0] rx_byte_o
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} rx_state_e;

	rx_state_e        state_q;
	logic [CNT_W-1:0] clk_cnt_q;
	logic [2:0]       bit_cnt_q;
	logic [7:0]       shift_q;
	logic             valid_q;
	logic             sample_bit;

	// Middle of a data bit
	assign sample_bit = (state_q == DATA) && (clk_cnt_q == FULL_BIT);

	// ==========================================================
	// Frame FSM
	// ==========================================================

	always_ff @(posedge clk_i or negedge enable_rst_ni) begin
		if (!enable_rst_ni) begin
			state_q   <= IDLE;
			clk_cnt_q <= '0;
			bit_cnt_q <= '0;
			valid_q   <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state_q)
				IDLE: begin
					clk_cnt_q <= '0;
					bit_cnt_q <= '0;
					if (!rx_i) begin
						state_q <= START;
					end
				end
				START: begin
					if (clk_cnt_q == HALF_BIT) begin
						clk_cnt_q <= '0;
						// Glitch filter, line must still be low
						state_q <= rx_i ? IDLE : DATA;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				DATA: begin
					if (sample_bit) begin
						clk_cnt_q <= '0;
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == 3'd7) begin
							state_q <= STOP;
						end
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				STOP: begin
					if (clk_cnt_q == FULL_BIT) begin
						// Byte delivered even on a bad stop bit
						clk_cnt_q <= '0;
						valid_q   <= 1'b1;
						state_q   <= IDLE;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk_i) begin
		if (sample_bit) begin
			shift_q <= {rx_i, shift_q[7:1]};
		end
	end

	assign rx_valid_o = valid_q;
	assign rx_byte_o  = shift_q;

endmodule

// File: word_packer.sv
`timescale 1ns/100ps

module word_packer import boot_pkg::*; #(
	parameter int ADDR_W      = 8,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic              clk_i,
	input  logic              enable_rst_ni,
	input  logic              rx_valid_i,
	input  logic [7:0]        rx_byte_i,
	input  logic              credit_return_i,
	output logic              push_o,
	output item_op_e          push_op_o,
	output logic [ADDR_W-1:0] push_addr_o,
	output logic [DATA_W-1:0] push_data_o,
	output logic              overrun_o
);

	localparam int CRED_W = $clog2(QUEUE_DEPTH + 1);
	localparam int LANE_W = $clog2(BYTES_PER_WORD);

	logic [LANE_W-1:0] lane_q;
	logic [DATA_W-1:0] word_q;
	logic [CRED_W-1:0] credit_q;
	logic [ADDR_W-1:0] addr_q;
	logic              done_q;
	logic              word_ready;
	logic              has_credit;
	logic              take;
	logic              is_done;
	logic [DATA_W-1:0] word_full;

	// Last byte goes straight into the top lane
	assign word_full  = {rx_byte_i, word_q[DATA_W-BYTE_W-1:0]};
	assign word_ready = rx_valid_i && !done_q && (lane_q == LANE_W'(BYTES_PER_WORD - 1));
	assign has_credit = (credit_q != '0);
	assign take       = word_ready && has_credit;
	assign is_done    = (word_full == DONE_WORD);

	// ==========================================================
	// Lanes, credits and addresses
	// ==========================================================

	always_ff @(posedge clk_i or negedge enable_rst_ni) begin
		if (!enable_rst_ni) begin
			lane_q    <= '0;
			credit_q  <= CRED_W'(QUEUE_DEPTH);
			addr_q    <= '0;
			done_q    <= 1'b0;
			push_o    <= 1'b0;
			overrun_o <= 1'b0;
		end else begin
			push_o <= take;
			if (rx_valid_i && !done_q) begin
				lane_q <= lane_q + 1'b1;
			end
			case ({take, credit_return_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
			if (take && is_done) begin
				done_q <= 1'b1;
			end
			if (take && !is_done) begin
				addr_q <= addr_q + 1'b1;
			end
			// Sticky, word is lost
			if (word_ready && !has_credit) begin
				overrun_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rx_valid_i && !done_q) begin
			word_q[lane_q*BYTE_W +: BYTE_W] <= rx_byte_i;
		end
		if (take) begin
			push_op_o   <= is_done ? ITEM_DONE : ITEM_WRITE;
			push_addr_o <= addr_q;
			push_data_o <= word_full;
		end
	end

	// Queue must never return more credits than it has slots
	a_credit_bound: assert property (@(posedge clk_i) disable iff (!enable_rst_ni)
		credit_q <= CRED_W'(QUEUE_DEPTH))
		else $error("credit count above queue depth: %0d", credit_q);

endmodule
